/* filelist.f */
+incdir+include
logic/bus_pkg.sv
logic/memory_map_pkg.sv
logic/bus_decoder.sv
logic/boot_rom.sv
logic/scratch_ram.sv
logic/clint.sv
logic/memory_subsystem.sv
tb/memory_subsystem_tb.sv

/* include/boot_rom_image.svh */
`ifndef boot_rom_image_svh
`define boot_rom_image_svh

// words past the end of the image read as zero
localparam int boot_image_words = 16;

// small start-up loop followed by a few constant words
localparam logic [bus_pkg::data_width-1:0] boot_image [boot_image_words] = '{
  32'h0000_0013,
  32'h0010_00b7,
  32'h0200_0137,
  32'h0010_0193,
  32'h0031_2023,
  32'h3004_6073,
  32'h0000_a203,
  32'h0012_0213,
  32'h0040_a023,
  32'h0000_006f,
  32'hdead_beef,
  32'h1234_5678,
  32'hcafe_f00d,
  32'h0bad_c0de,
  32'h5555_aaaa,
  32'h8000_0001
};

`endif

/* logic/boot_rom.sv */
`timescale 1ns/1ps

module boot_rom (
  input  logic                            clock,
  input  logic                            reset,
  input  logic                            valid,
  input  bus_pkg::bus_request_t           request,
  output logic                            ready,
  output logic [bus_pkg::data_width-1:0]  rdata
);

  `include "boot_rom_image.svh"

  localparam int index_width = $clog2(memory_map_pkg::rom_words);

  logic [bus_pkg::data_width-1:0] rom_array [memory_map_pkg::rom_words];
  logic [index_width-1:0]         word_index;

  // the image covers the start of the rom, the rest is zero
  initial begin
    for (int i = 0; i < memory_map_pkg::rom_words; i++) begin
      rom_array[i] = (i < boot_image_words) ? boot_image[i] : '0;
    end
  end

  assign word_index = request.addr[index_width+1:2];

  always_ff @(posedge clock) begin
    if (reset) begin
      ready <= 1'b0;
    end else begin
      ready <= valid && !ready;
    end
  end

  // writes are answered like reads and leave the contents alone
  always_ff @(posedge clock) begin
    if (valid && !ready) begin
      rdata <= rom_array[word_index];
    end
  end

endmodule

/* logic/bus_decoder.sv */
`timescale 1ns/1ps

module bus_decoder (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                mem_valid,
  input  bus_pkg::bus_request_t               mem_request,
  output logic                                mem_ready,
  output bus_pkg::bus_response_t              mem_response,
  output bus_pkg::bus_request_t               slave_request,
  output logic                                rom_valid,
  output logic                                ram_valid,
  output logic                                clint_valid,
  input  logic                                rom_ready,
  input  logic                                ram_ready,
  input  logic                                clint_ready,
  input  logic [bus_pkg::data_width-1:0]      rom_rdata,
  input  logic [bus_pkg::data_width-1:0]      ram_rdata,
  input  logic [bus_pkg::data_width-1:0]      clint_rdata
);

  logic                            error_valid;
  logic                            error_ready;
  logic [bus_pkg::addr_width-1:0]  base_addr;

  // --------------------------------------------------
  // region decode
  // --------------------------------------------------

  // clint is checked first, then ram, then rom
  always_comb begin
    rom_valid = 1'b0;
    ram_valid = 1'b0;
    clint_valid = 1'b0;
    error_valid = 1'b0;
    base_addr = '0;

    if (mem_request.addr >= memory_map_pkg::clint_base_addr &&
        mem_request.addr < memory_map_pkg::clint_top_addr) begin
      clint_valid = mem_valid;
      base_addr = memory_map_pkg::clint_base_addr;
    end else if (mem_request.addr >= memory_map_pkg::ram_base_addr &&
                 mem_request.addr < memory_map_pkg::ram_top_addr) begin
      ram_valid = mem_valid;
      base_addr = memory_map_pkg::ram_base_addr;
    end else if (mem_request.addr >= memory_map_pkg::rom_base_addr &&
                 mem_request.addr < memory_map_pkg::rom_top_addr) begin
      rom_valid = mem_valid;
      base_addr = memory_map_pkg::rom_base_addr;
    end else begin
      error_valid = mem_valid;
    end

    // every slave sees the offset into its own region
    slave_request = mem_request;
    slave_request.addr = mem_request.addr - base_addr;
  end

  // --------------------------------------------------
  // error responder for unmapped addresses
  // --------------------------------------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      error_ready <= 1'b0;
    end else begin
      // a held valid must not give a second pulse
      error_ready <= error_valid && !error_ready;
    end
  end

  // --------------------------------------------------
  // response multiplexing
  // --------------------------------------------------

  assign mem_ready = rom_ready | ram_ready | clint_ready | error_ready;

  always_comb begin
    mem_response = '0;
    if (rom_ready) begin
      mem_response.rdata = rom_rdata;
    end else if (ram_ready) begin
      mem_response.rdata = ram_rdata;
    end else if (clint_ready) begin
      mem_response.rdata = clint_rdata;
    end else if (error_ready) begin
      mem_response.error = 1'b1;
    end
  end

  // only one responder may own the bus in a cycle
  assert property (@(posedge clock) disable iff (reset)
    $onehot0({rom_ready, ram_ready, clint_ready, error_ready}))
    else $error("more than one responder ready in the same cycle");

  // a ready pulse always answers a request seen the cycle before
  assert property (@(posedge clock) disable iff (reset)
    $rose(mem_ready) |-> $past(mem_valid))
    else $error("mem_ready rose without a request");

endmodule

/* logic/bus_pkg.sv */
package bus_pkg;

  // ------------------------------------------------
  // word sizes of the processor memory bus
  // ------------------------------------------------

  localparam int addr_width = 32;
  localparam int data_width = 32;
  localparam int strb_width = data_width / 8;

  // ------------------------------------------------
  // request and response
  // ------------------------------------------------

  // travels with the valid level of the master, all strobes zero means a read
  typedef struct packed {
    logic [addr_width-1:0] addr;
    logic [data_width-1:0] wdata;
    logic [strb_width-1:0] wstrb;
  } bus_request_t;

  // only meaningful while ready is high
  typedef struct packed {
    logic [data_width-1:0] rdata;
    logic                  error;
  } bus_response_t;

endpackage

/* logic/clint.sv */
`timescale 1ns/1ps

module clint (
  input  logic                            clock,
  input  logic                            reset,
  input  logic                            valid,
  input  bus_pkg::bus_request_t           request,
  output logic                            ready,
  output logic [bus_pkg::data_width-1:0]  rdata,
  output logic                            msip,
  output logic                            mtip
);

  logic [63:0]                    mtime;
  logic [63:0]                    mtimecmp;
  logic                           accept;
  logic                           is_write;
  logic                           sel_msip;
  logic                           sel_cmp_lo;
  logic                           sel_cmp_hi;
  logic                           sel_time_lo;
  logic                           sel_time_hi;
  logic                           mtime_write;
  logic [bus_pkg::data_width-1:0] read_word;

  function automatic logic [31:0] merge_bytes(
    input logic [31:0] old_word,
    input logic [31:0] new_word,
    input logic [3:0]  strobes
  );
    logic [31:0] merged;
    merged = old_word;
    for (int i = 0; i < 4; i++) begin
      if (strobes[i]) begin
        merged[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return merged;
  endfunction

  // --------------------------------------------------
  // register select
  // --------------------------------------------------

  assign accept = valid && !ready;
  assign is_write = |request.wstrb;

  assign sel_msip = accept && request.addr == memory_map_pkg::clint_msip_offset;
  assign sel_cmp_lo = accept && request.addr == memory_map_pkg::clint_mtimecmp_lo_offset;
  assign sel_cmp_hi = accept && request.addr == memory_map_pkg::clint_mtimecmp_hi_offset;
  assign sel_time_lo = accept && request.addr == memory_map_pkg::clint_mtime_lo_offset;
  assign sel_time_hi = accept && request.addr == memory_map_pkg::clint_mtime_hi_offset;

  assign mtime_write = is_write && (sel_time_lo || sel_time_hi);

  always_comb begin
    read_word = '0;
    if (sel_msip) read_word = {31'b0, msip};
    if (sel_cmp_lo) read_word = mtimecmp[31:0];
    if (sel_cmp_hi) read_word = mtimecmp[63:32];
    if (sel_time_lo) read_word = mtime[31:0];
    if (sel_time_hi) read_word = mtime[63:32];
  end

  // --------------------------------------------------
  // timer, compare and software interrupt
  // --------------------------------------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      ready <= 1'b0;
      mtime <= '0;
      mtimecmp <= '1;
      msip <= 1'b0;
      mtip <= 1'b0;
    end else begin
      ready <= accept;
      // the compare is registered, so mtip trails both counters by a clock
      mtip <= mtime >= mtimecmp;

      // a written mtime is loaded as is and counting resumes from there
      if (sel_time_lo && is_write) begin
        mtime <= {mtime[63:32], merge_bytes(mtime[31:0], request.wdata, request.wstrb)};
      end else if (sel_time_hi && is_write) begin
        mtime <= {merge_bytes(mtime[63:32], request.wdata, request.wstrb), mtime[31:0]};
      end else begin
        mtime <= mtime + 64'd1;
      end

      if (sel_cmp_lo) begin
        mtimecmp[31:0] <= merge_bytes(mtimecmp[31:0], request.wdata, request.wstrb);
      end
      if (sel_cmp_hi) begin
        mtimecmp[63:32] <= merge_bytes(mtimecmp[63:32], request.wdata, request.wstrb);
      end
      if (sel_msip && request.wstrb[0]) begin
        msip <= request.wdata[0];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      rdata <= read_word;
    end
  end

  assert property (@(posedge clock) disable iff (reset)
    !$past(reset) && !$past(mtime_write) |-> mtime == $past(mtime) + 64'd1)
    else $error("mtime did not advance by one");

endmodule

/* logic/memory_map_pkg.sv */
package memory_map_pkg;

  // ------------------------------------------------
  // slave regions, top address is exclusive
  // ------------------------------------------------

  localparam logic [bus_pkg::addr_width-1:0] rom_base_addr = 32'h0000_0000;
  localparam logic [bus_pkg::addr_width-1:0] rom_top_addr = 32'h0000_0400;

  localparam logic [bus_pkg::addr_width-1:0] ram_base_addr = 32'h0010_0000;
  localparam logic [bus_pkg::addr_width-1:0] ram_top_addr = 32'h0010_1000;

  localparam logic [bus_pkg::addr_width-1:0] clint_base_addr = 32'h0200_0000;
  localparam logic [bus_pkg::addr_width-1:0] clint_top_addr = 32'h0201_0000;

  // word depths follow from the region sizes
  localparam int rom_words = int'((rom_top_addr - rom_base_addr) >> 2);
  localparam int ram_words = int'((ram_top_addr - ram_base_addr) >> 2);

  // ------------------------------------------------
  // clint register offsets from clint_base_addr
  // ------------------------------------------------

  localparam logic [bus_pkg::addr_width-1:0] clint_msip_offset = 32'h0000_0000;
  localparam logic [bus_pkg::addr_width-1:0] clint_mtimecmp_lo_offset = 32'h0000_4000;
  localparam logic [bus_pkg::addr_width-1:0] clint_mtimecmp_hi_offset = 32'h0000_4004;
  localparam logic [bus_pkg::addr_width-1:0] clint_mtime_lo_offset = 32'h0000_BFF8;
  localparam logic [bus_pkg::addr_width-1:0] clint_mtime_hi_offset = 32'h0000_BFFC;

endpackage

/* logic/memory_subsystem.sv */
`timescale 1ns/1ps

module memory_subsystem (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    mem_valid,
  input  bus_pkg::bus_request_t   mem_request,
  output logic                    mem_ready,
  output bus_pkg::bus_response_t  mem_response,
  output logic                    msip,
  output logic                    mtip
);

  bus_pkg::bus_request_t          slave_request;
  logic                           rom_valid;
  logic                           ram_valid;
  logic                           clint_valid;
  logic                           rom_ready;
  logic                           ram_ready;
  logic                           clint_ready;
  logic [bus_pkg::data_width-1:0] rom_rdata;
  logic [bus_pkg::data_width-1:0] ram_rdata;
  logic [bus_pkg::data_width-1:0] clint_rdata;

  bus_decoder u_decoder (
    .clock         (clock),
    .reset         (reset),
    .mem_valid     (mem_valid),
    .mem_request   (mem_request),
    .mem_ready     (mem_ready),
    .mem_response  (mem_response),
    .slave_request (slave_request),
    .rom_valid     (rom_valid),
    .ram_valid     (ram_valid),
    .clint_valid   (clint_valid),
    .rom_ready     (rom_ready),
    .ram_ready     (ram_ready),
    .clint_ready   (clint_ready),
    .rom_rdata     (rom_rdata),
    .ram_rdata     (ram_rdata),
    .clint_rdata   (clint_rdata)
  );

  // all slaves share the offset request, only the valids differ
  boot_rom u_rom (
    .clock   (clock),
    .reset   (reset),
    .valid   (rom_valid),
    .request (slave_request),
    .ready   (rom_ready),
    .rdata   (rom_rdata)
  );

  scratch_ram u_ram (
    .clock   (clock),
    .reset   (reset),
    .valid   (ram_valid),
    .request (slave_request),
    .ready   (ram_ready),
    .rdata   (ram_rdata)
  );

  clint u_clint (
    .clock   (clock),
    .reset   (reset),
    .valid   (clint_valid),
    .request (slave_request),
    .ready   (clint_ready),
    .rdata   (clint_rdata),
    .msip    (msip),
    .mtip    (mtip)
  );

endmodule

/* logic/scratch_ram.sv */
`timescale 1ns/1ps

module scratch_ram (
  input  logic                            clock,
  input  logic                            reset,
  input  logic                            valid,
  input  bus_pkg::bus_request_t           request,
  output logic                            ready,
  output logic [bus_pkg::data_width-1:0]  rdata
);

  localparam int index_width = $clog2(memory_map_pkg::ram_words);

  logic [bus_pkg::data_width-1:0] ram_array [memory_map_pkg::ram_words];
  logic [index_width-1:0]         word_index;
  logic                           accept;

  assign word_index = request.addr[index_width+1:2];

  // first cycle of a request, the cycle with ready high is skipped
  assign accept = valid && !ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      ready <= 1'b0;
    end else begin
      ready <= accept;
    end
  end

  // --------------------------------------------------
  // storage
  // --------------------------------------------------

  // a write answers with the word as it stood before the write
  always_ff @(posedge clock) begin
    if (accept) begin
      rdata <= ram_array[word_index];
      for (int i = 0; i < bus_pkg::strb_width; i++) begin
        if (request.wstrb[i]) begin
          ram_array[word_index][8*i +: 8] <= request.wdata[8*i +: 8];
        end
      end
    end
  end

  // the decoder must hand over an offset that stays inside the ram
  assert property (@(posedge clock) disable iff (reset)
    valid |-> (request.addr >> 2) < memory_map_pkg::ram_words)
    else $error("ram offset beyond the last word");

endmodule

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
  --top-module memory_subsystem_tb -o memory_subsystem_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/memory_subsystem_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST OK"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* tb/memory_subsystem_tb.sv */
`timescale 1ns/1ps

module memory_subsystem_tb;

  localparam int clock_period = 20;
  localparam int rom_accesses = 64;
  localparam int ram_accesses = 200;
  localparam int unmapped_accesses = 32;
  localparam int clint_rounds = 8;
  // ram prefill, up to two accesses per rom draw, then ram, unmapped and clint traffic
  localparam int total_accesses = memory_map_pkg::ram_words + 2 * rom_accesses
    + ram_accesses + unmapped_accesses + 16 * clint_rounds;
  localparam int timeout_cycles = 4 * total_accesses + 200;

  // boot_rom has already set the include guard
  `undef boot_rom_image_svh
  `include "boot_rom_image.svh"

  logic                   clock;
  logic                   reset;
  logic                   mem_valid;
  bus_pkg::bus_request_t  mem_request;
  logic                   mem_ready;
  bus_pkg::bus_response_t mem_response;
  logic                   msip;
  logic                   mtip;

  integer      seed;
  int          edge_count;
  int          error_count;
  int          check_count;
  int          tests_run;
  int          tests_failed;
  logic [31:0] ram_model [memory_map_pkg::ram_words];

  memory_subsystem u_dut (
    .clock        (clock),
    .reset        (reset),
    .mem_valid    (mem_valid),
    .mem_request  (mem_request),
    .mem_ready    (mem_ready),
    .mem_response (mem_response),
    .msip         (msip),
    .mtip         (mtip)
  );

  initial begin
    clock = 1'b0;
    forever #(clock_period / 2) clock = ~clock;
  end

  // counts rising edges, so the distance between two accepting edges is known
  always @(posedge clock) begin
    if (reset) begin
      edge_count <= 0;
    end else begin
      edge_count <= edge_count + 1;
    end
  end

  initial begin : watchdog
    #(timeout_cycles * clock_period);
    $display("watchdog expired after %0d clocks before the tests were done", timeout_cycles);
    $display("TEST FAILED");
    $finish;
  end

  // --------------------------------------------------
  // model helpers
  // --------------------------------------------------

  function automatic logic [31:0] rand_word();
    rand_word = $random(seed);
  endfunction

  function automatic logic is_mapped(input logic [31:0] addr);
    return (addr >= memory_map_pkg::rom_base_addr && addr < memory_map_pkg::rom_top_addr) ||
           (addr >= memory_map_pkg::ram_base_addr && addr < memory_map_pkg::ram_top_addr) ||
           (addr >= memory_map_pkg::clint_base_addr && addr < memory_map_pkg::clint_top_addr);
  endfunction

  function automatic logic [31:0] merge_strobes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0] strobes);
    logic [31:0] merged;
    merged = old_word;
    for (int i = 0; i < 4; i++) begin
      if (strobes[i]) merged[8*i +: 8] = new_word[8*i +: 8];
    end
    return merged;
  endfunction

  function automatic logic [31:0] fill_pattern(input logic [31:0] addr);
    return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a_a5a5;
  endfunction

  function automatic logic [31:0] rom_word(input int index);
    return (index < boot_image_words) ? boot_image[index] : 32'h0;
  endfunction

  function automatic bus_pkg::bus_response_t data_response(input logic [31:0] rdata);
    bus_pkg::bus_response_t response;
    response.rdata = rdata;
    response.error = 1'b0;
    return response;
  endfunction

  // --------------------------------------------------
  // compare tasks and bus access
  // --------------------------------------------------

  task automatic check_response(input string name, input bus_pkg::bus_response_t expected,
                                input bus_pkg::bus_response_t actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED at %0t: mem_response (%s) expected %h err %b, actual %h err %b",
               $time, name, expected.rdata, expected.error, actual.rdata, actual.error);
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED at %0t: %s expected %b, actual %b", $time, name, expected, actual);
    end
  endtask

  // starts and ends just after a falling edge
  task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb, output bus_pkg::bus_response_t response,
                            output int accept_edge);
    int waited;
    mem_request.addr = addr;
    mem_request.wdata = wdata;
    mem_request.wstrb = wstrb;
    mem_valid = 1'b1;
    @(negedge clock);
    waited = 1;
    while (!mem_ready && waited < 4) begin
      @(negedge clock);
      waited++;
    end
    if (!mem_ready) begin
      error_count++;
      $display("no mem_ready within 4 clocks for address %h at %0t", addr, $time);
    end else if (waited != 1) begin
      error_count++;
      $display("mem_ready for address %h came %0d clocks after the request", addr, waited);
    end
    response = mem_response;
    accept_edge = edge_count - waited + 1;
    // the request stays up over the next edge and must not be answered twice
    @(negedge clock);
    check_bit("mem_ready after pulse", 1'b0, mem_ready);
    mem_valid = 1'b0;
    mem_request = '0;
  endtask

  task automatic wait_clocks(input int count);
    repeat (count) @(negedge clock);
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (error_count == errors_before) begin
      $display("%s: passed", name);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, error_count - errors_before);
    end
  endtask

  // --------------------------------------------------
  // tests
  // --------------------------------------------------

  initial begin : stimulus
    bus_pkg::bus_response_t response;
    bus_pkg::bus_response_t error_response;
    int                     accept_edge;
    int                     first_edge;
    int                     errors_before;
    int                     index;
    logic [31:0]            addr;
    logic [31:0]            wdata;
    logic [31:0]            wdata_hi;
    logic [31:0]            draw;
    logic [3:0]             wstrb;
    logic [31:0]            clint;

    seed = 32'he3739f97;
    error_count = 0;
    check_count = 0;
    tests_run = 0;
    tests_failed = 0;
    reset = 1'b1;
    mem_valid = 1'b0;
    mem_request = '0;
    repeat (3) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    check_bit("mem_ready", 1'b0, mem_ready);
    check_bit("msip", 1'b0, msip);
    check_bit("mtip", 1'b0, mtip);

    errors_before = error_count;
    for (int n = 0; n < rom_accesses; n++) begin
      index = rand_word() % memory_map_pkg::rom_words;
      addr = memory_map_pkg::rom_base_addr + 32'(index * 4);
      if (rand_word() % 2 == 1) begin
        draw = rand_word();
        wstrb = (draw[3:0] == 4'h0) ? 4'hf : draw[3:0];
        bus_access(addr, rand_word(), wstrb, response, accept_edge);
        check_response("rom write response", data_response(rom_word(index)), response);
      end
      bus_access(addr, 32'h0, 4'h0, response, accept_edge);
      check_response("rom read", data_response(rom_word(index)), response);
    end
    finish_test("test 1 rom reads and ignored writes", errors_before);

    errors_before = error_count;
    for (int i = 0; i < memory_map_pkg::ram_words; i++) begin
      addr = memory_map_pkg::ram_base_addr + 32'(i * 4);
      ram_model[i] = fill_pattern(addr);
      bus_access(addr, ram_model[i], 4'hf, response, accept_edge);
    end
    for (int n = 0; n < ram_accesses; n++) begin
      index = rand_word() % memory_map_pkg::ram_words;
      addr = memory_map_pkg::ram_base_addr + 32'(index * 4);
      draw = rand_word();
      wstrb = draw[8] ? 4'h0 : draw[3:0];
      wdata = rand_word();
      bus_access(addr, wdata, wstrb, response, accept_edge);
      check_response("ram response", data_response(ram_model[index]), response);
      ram_model[index] = merge_strobes(ram_model[index], wdata, wstrb);
    end
    finish_test("test 2 ram byte writes and reads", errors_before);

    errors_before = error_count;
    error_response.rdata = 32'h0;
    error_response.error = 1'b1;
    for (int n = 0; n < unmapped_accesses; n++) begin
      addr = rand_word();
      while (is_mapped(addr)) addr = rand_word();
      draw = rand_word();
      bus_access(addr, rand_word(), draw[3:0], response, accept_edge);
      check_response("unmapped response", error_response, response);
    end
    finish_test("test 3 unmapped addresses", errors_before);

    errors_before = error_count;
    clint = memory_map_pkg::clint_base_addr;
    bus_access(clint + memory_map_pkg::clint_mtimecmp_lo_offset, 0, 4'h0, response, accept_edge);
    check_response("mtimecmp_lo after reset", data_response(32'hffff_ffff), response);
    bus_access(clint + memory_map_pkg::clint_mtimecmp_hi_offset, 0, 4'h0, response, accept_edge);
    check_response("mtimecmp_hi after reset", data_response(32'hffff_ffff), response);
    for (int n = 0; n < clint_rounds; n++) begin
      wdata = rand_word();
      wdata_hi = rand_word();
      bus_access(clint + memory_map_pkg::clint_mtimecmp_lo_offset, wdata, 4'hf, response,
                 accept_edge);
      bus_access(clint + memory_map_pkg::clint_mtimecmp_hi_offset, wdata_hi, 4'hf, response,
                 accept_edge);
      bus_access(clint + memory_map_pkg::clint_mtimecmp_lo_offset, 0, 4'h0, response, accept_edge);
      check_response("mtimecmp_lo", data_response(wdata), response);
      bus_access(clint + memory_map_pkg::clint_mtimecmp_hi_offset, 0, 4'h0, response, accept_edge);
      check_response("mtimecmp_hi", data_response(wdata_hi), response);
      wdata = rand_word();
      bus_access(clint + memory_map_pkg::clint_msip_offset, wdata, 4'hf, response, accept_edge);
      check_bit("msip", wdata[0], msip);
      bus_access(clint + memory_map_pkg::clint_msip_offset, 0, 4'h0, response, accept_edge);
      check_response("msip register", data_response({31'h0, wdata[0]}), response);
    end
    finish_test("test 4 mtimecmp and msip", errors_before);

    errors_before = error_count;
    for (int n = 0; n < clint_rounds; n++) begin
      wdata = rand_word();
      bus_access(clint + memory_map_pkg::clint_mtime_lo_offset, wdata, 4'hf, response,
                 first_edge);
      wait_clocks(rand_word() % 4);
      index = rand_word() % memory_map_pkg::rom_words;
      bus_access(32'(index * 4), 0, 4'h0, response, accept_edge);
      check_response("rom read between timer accesses", data_response(rom_word(index)), response);
      wait_clocks(rand_word() % 4);
      bus_access(clint + memory_map_pkg::clint_mtime_lo_offset, 0, 4'h0, response, accept_edge);
      // mtime holds the written value for the first clock after the write
      check_response("mtime_lo", data_response(wdata + 32'(accept_edge - first_edge - 1)),
                     response);

      bus_access(clint + memory_map_pkg::clint_mtimecmp_hi_offset, 32'hffff_ffff, 4'hf,
                 response, accept_edge);
      bus_access(clint + memory_map_pkg::clint_mtimecmp_lo_offset, rand_word(), 4'hf,
                 response, accept_edge);
      check_bit("mtip with compare far ahead", 1'b0, mtip);
      bus_access(clint + memory_map_pkg::clint_mtimecmp_lo_offset, 0, 4'hf, response,
                 accept_edge);
      bus_access(clint + memory_map_pkg::clint_mtimecmp_hi_offset, 0, 4'hf, response,
                 accept_edge);
      check_bit("mtip with compare below mtime", 1'b1, mtip);
    end
    finish_test("test 5 mtime and timer interrupt", errors_before);

    $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, check_count, error_count);
    if (error_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
